// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= *** PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
+incdir+src
src/mips_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mips_core.sv
test/tb_mips_core.sv

// File: src/decode_stage.sv
`include "mips_defs.svh"

module decode_stage import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  fetch_t    fetch_i,
	output reg_addr_t rs_addr_o,
	output reg_addr_t rt_addr_o,
	input  word_t     rs_data_i,
	input  word_t     rt_data_i,
	input  wb_t       ex_fwd_i,
	input  wb_t       wb_fwd_i,
	output exec_t     exec_o,
	output branch_t   branch_o
);

	fetch_t            fetch_q;
	logic [5:0]        op;
	logic [5:0]        funct;
	logic [4:0]        shamt;
	reg_addr_t         rs;
	reg_addr_t         rt;
	reg_addr_t         rd;
	logic [`IMM_W-1:0] imm16;
	word_t             pc_plus_4;
	word_t             pc_plus_8;
	word_t             br_offset;
	word_t             jump_target;

	alu_op_e   alu_op;
	logic      use_rs;
	logic      use_rt;
	word_t     imm;
	reg_addr_t dest_addr;
	logic      wr_en;
	logic      is_movn;
	logic      is_movz;
	logic      inst_ok;
	word_t     opa;
	word_t     opb;
	logic      taken;
	word_t     target;
	exec_t     exec_d;
	branch_t   branch_d;

	// newest producer wins and $zero is never forwarded
	function automatic word_t fwd_sel(reg_addr_t a, word_t rf_data, wb_t ex, wb_t wb);
		if (ex.we && ex.addr == a && a != '0)
			return ex.data;
		if (wb.we && wb.addr == a && a != '0)
			return wb.data;
		return rf_data;
	endfunction

	function automatic alu_op_e fn_to_alu(logic [5:0] fn);
		case (fn)
			`FN_SLL, `FN_SLLV: return ALU_SLL;
			`FN_SRL, `FN_SRLV: return ALU_SRL;
			`FN_SRA, `FN_SRAV: return ALU_SRA;
			`FN_MOVN, `FN_MOVZ: return ALU_MOVE;
			`FN_ADDU: return ALU_ADD;
			`FN_SUBU: return ALU_SUB;
			`FN_AND: return ALU_AND;
			`FN_OR: return ALU_OR;
			`FN_XOR: return ALU_XOR;
			`FN_NOR: return ALU_NOR;
			`FN_SLT: return ALU_SLT;
			`FN_SLTU: return ALU_SLTU;
			`FN_JALR: return ALU_LINK;
			default: return ALU_NOP;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fetch_q <= '0;
		end else begin
			fetch_q <= fetch_i;
		end
	end

	assign op    = fetch_q.inst[31:26];
	assign rs    = fetch_q.inst[25:21];
	assign rt    = fetch_q.inst[20:16];
	assign rd    = fetch_q.inst[15:11];
	assign shamt = fetch_q.inst[10:6];
	assign funct = fetch_q.inst[5:0];
	assign imm16 = fetch_q.inst[`IMM_W-1:0];

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	assign pc_plus_4   = fetch_q.pc + 32'd4;
	assign pc_plus_8   = fetch_q.pc + 32'd8; // link address
	assign br_offset   = {{(`DATA_W-`IMM_W-2){imm16[`IMM_W-1]}}, imm16, 2'b00};
	assign jump_target = {pc_plus_4[31:28], fetch_q.inst[25:0], 2'b00};

	always_comb begin
		alu_op    = ALU_NOP;
		use_rs    = 1'b0;
		use_rt    = 1'b0;
		imm       = '0;
		dest_addr = rd;
		wr_en     = 1'b0;
		is_movn   = 1'b0;
		is_movz   = 1'b0;
		inst_ok   = 1'b0; // invalid until a pattern matches
		case (op)
			`OP_SPECIAL: begin
				alu_op  = fn_to_alu(funct);
				is_movn = (funct == `FN_MOVN);
				is_movz = (funct == `FN_MOVZ);
				case (funct)
					`FN_SLL, `FN_SRL, `FN_SRA: begin
						inst_ok = (rs == '0);
						use_rt  = 1'b1;
						imm     = word_t'(shamt); // shift amount rides in opa
						wr_en   = 1'b1;
					end
					`FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_MOVN, `FN_MOVZ,
					`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
					`FN_SLT, `FN_SLTU: begin
						inst_ok = (shamt == '0);
						use_rs  = 1'b1;
						use_rt  = 1'b1;
						wr_en   = 1'b1;
					end
					`FN_JR, `FN_JALR: begin
						inst_ok = (shamt == '0);
						use_rs  = 1'b1;
						wr_en   = (funct == `FN_JALR); // jalr links into rd
					end
					default: ;
				endcase
			end
			`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				inst_ok   = 1'b1;
				use_rs    = 1'b1; // rs is zero for lui
				wr_en     = 1'b1;
				dest_addr = rt;
				case (op)
					`OP_ADDIU: alu_op = ALU_ADD;
					`OP_SLTI: alu_op = ALU_SLT;
					`OP_SLTIU: alu_op = ALU_SLTU;
					`OP_ANDI: alu_op = ALU_AND;
					`OP_XORI: alu_op = ALU_XOR;
					default: alu_op = ALU_OR;
				endcase
				if (op == `OP_LUI)
					imm = {imm16, {(`DATA_W-`IMM_W){1'b0}}};
				else if (op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI)
					imm = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
				else
					imm = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
			end
			`OP_J: inst_ok = 1'b1;
			`OP_JAL: begin
				inst_ok   = 1'b1;
				alu_op    = ALU_LINK;
				wr_en     = 1'b1;
				dest_addr = `LINK_REG;
			end
			`OP_BEQ, `OP_BNE: begin
				inst_ok = 1'b1;
				use_rs  = 1'b1;
				use_rt  = 1'b1;
			end
			`OP_BLEZ, `OP_BGTZ: begin
				inst_ok = 1'b1;
				use_rs  = 1'b1;
			end
			`OP_REGIMM: begin
				use_rs = 1'b1;
				if (rt == `RT_BLTZ || rt == `RT_BGEZ) begin
					inst_ok = 1'b1;
				end else if (rt == `RT_BLTZAL || rt == `RT_BGEZAL) begin
					inst_ok   = 1'b1;
					alu_op    = ALU_LINK; // link written whether taken or not
					wr_en     = 1'b1;
					dest_addr = `LINK_REG;
				end
			end
			default: ;
		endcase
		if (!inst_ok) begin
			alu_op = ALU_NOP;
			wr_en  = 1'b0;
		end
	end

	// an operand that is not read takes the immediate
	assign opa = use_rs ? fwd_sel(rs, rs_data_i, ex_fwd_i, wb_fwd_i) : imm;
	assign opb = use_rt ? fwd_sel(rt, rt_data_i, ex_fwd_i, wb_fwd_i) : imm;

	always_comb begin
		taken  = 1'b0;
		target = pc_plus_4 + br_offset;
		case (op)
			`OP_J, `OP_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			`OP_BEQ: taken = (opa == opb);
			`OP_BNE: taken = (opa != opb);
			`OP_BLEZ: taken = opa[`DATA_W-1] || (opa == '0);
			`OP_BGTZ: taken = !opa[`DATA_W-1] && (opa != '0);
			`OP_REGIMM: taken = rt[0] ? !opa[`DATA_W-1] : opa[`DATA_W-1];
			`OP_SPECIAL: begin
				if (funct == `FN_JR || funct == `FN_JALR) begin
					taken  = 1'b1;
					target = opa;
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		exec_d.valid     = fetch_q.valid;
		exec_d.op        = alu_op;
		exec_d.opa       = opa;
		exec_d.opb       = opb;
		exec_d.link      = pc_plus_8;
		exec_d.dest.addr = dest_addr;
		exec_d.dest.we   = wr_en && dest_addr != '0 &&
			(!is_movn || opb != '0) && (!is_movz || opb == '0); // movn/movz on forwarded rt
		branch_d.taken   = fetch_q.valid && inst_ok && taken;
		branch_d.target  = branch_d.taken ? target : '0;
		branch_d.invalid = fetch_q.valid && !inst_ok;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exec_o   <= '0;
			branch_o <= '0;
		end else begin
			exec_o   <= exec_d;
			branch_o <= branch_d;
		end
	end

endmodule

// File: src/execute_stage.sv
module execute_stage import mips_pkg::*; (
	input  logic  clk,
	input  logic  rst_n_i,
	input  exec_t exec_i,
	output wb_t   ex_fwd_o,
	output wb_t   wb_o
);

	word_t      result;
	logic [4:0] sa;

	assign sa = exec_i.opa[4:0]; // shift amount, from shamt or rs

	always_comb begin
		case (exec_i.op)
			ALU_OR: result = exec_i.opa | exec_i.opb;
			ALU_AND: result = exec_i.opa & exec_i.opb;
			ALU_XOR: result = exec_i.opa ^ exec_i.opb;
			ALU_NOR: result = ~(exec_i.opa | exec_i.opb);
			ALU_ADD: result = exec_i.opa + exec_i.opb; // wraps, no overflow trap
			ALU_SUB: result = exec_i.opa - exec_i.opb;
			ALU_SLT: result = word_t'($signed(exec_i.opa) < $signed(exec_i.opb));
			ALU_SLTU: result = word_t'(exec_i.opa < exec_i.opb);
			ALU_SLL: result = exec_i.opb << sa;
			ALU_SRL: result = exec_i.opb >> sa;
			ALU_SRA: result = word_t'($signed(exec_i.opb) >>> sa);
			ALU_MOVE: result = exec_i.opa; // write gated in decode
			ALU_LINK: result = exec_i.link;
			default: result = '0;
		endcase
	end

	// unregistered result, newest forwarding source for decode
	always_comb begin
		ex_fwd_o.we   = exec_i.valid && exec_i.dest.we;
		ex_fwd_o.addr = exec_i.dest.addr;
		ex_fwd_o.data = result;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_o <= '0;
		end else begin
			wb_o <= ex_fwd_o;
		end
	end

endmodule

// File: src/mips_core.sv
module mips_core import mips_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  fetch_t  fetch_i,
	output wb_t     wb_o,
	output branch_t branch_o
);

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_data;
	word_t     rt_data;
	exec_t     exec_q;
	wb_t       ex_fwd;

	decode_stage i_decode (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.fetch_i   (fetch_i),
		.rs_addr_o (rs_addr),
		.rt_addr_o (rt_addr),
		.rs_data_i (rs_data),
		.rt_data_i (rt_data),
		.ex_fwd_i  (ex_fwd),
		.wb_fwd_i  (wb_o), // older source, one stage behind execute
		.exec_o    (exec_q),
		.branch_o  (branch_o)
	);

	execute_stage i_execute (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.exec_i   (exec_q),
		.ex_fwd_o (ex_fwd),
		.wb_o     (wb_o)
	);

	// write port is wb_o itself, lands on the next edge
	reg_file i_reg_file (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rs_addr_i (rs_addr),
		.rt_addr_i (rt_addr),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.wr_i      (wb_o)
	);

endmodule

// File: src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_W   32
`define REG_AW   5
`define NUM_REGS 32
`define INST_W   32
`define IMM_W    16
`define LINK_REG 5'd31 // ra

// primary opcode, inst[31:26]
`define OP_SPECIAL 6'h00
`define OP_REGIMM  6'h01
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f

// special funct, inst[5:0]
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_SLLV 6'h04
`define FN_SRLV 6'h06
`define FN_SRAV 6'h07
`define FN_JR   6'h08
`define FN_JALR 6'h09
`define FN_MOVZ 6'h0a
`define FN_MOVN 6'h0b
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2a
`define FN_SLTU 6'h2b

// regimm rt field, bit 0 selects ge over lt
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`endif

// File: src/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`INST_W-1:0] inst_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_NOP  = 4'd0, // keep at zero, reset value of exec_t
		ALU_OR   = 4'd1,
		ALU_AND  = 4'd2,
		ALU_XOR  = 4'd3,
		ALU_NOR  = 4'd4,
		ALU_ADD  = 4'd5,
		ALU_SUB  = 4'd6,
		ALU_SLT  = 4'd7,
		ALU_SLTU = 4'd8,
		ALU_SLL  = 4'd9,
		ALU_SRL  = 4'd10,
		ALU_SRA  = 4'd11,
		ALU_MOVE = 4'd12,
		ALU_LINK = 4'd13
	} alu_op_e;

	typedef struct packed {
		logic  valid;
		word_t pc;
		inst_t inst;
	} fetch_t;

	// register write, also used as a forwarding source
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	typedef struct packed {
		logic  taken;
		word_t target;
		logic  invalid;
	} branch_t;

	typedef struct packed {
		logic    valid;
		alu_op_e op;
		word_t   opa; // rs or shift amount
		word_t   opb; // rt or immediate
		word_t   link; // pc + 8
		struct packed {
			logic      we;
			reg_addr_t addr;
		} dest;
	} exec_t;

endpackage

// File: src/reg_file.sv
`include "mips_defs.svh"

module reg_file import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  reg_addr_t rs_addr_i,
	input  reg_addr_t rt_addr_i,
	output word_t     rs_data_o,
	output word_t     rt_data_o,
	input  wb_t       wr_i
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.we && wr_i.addr != '0) begin // $zero stays zero
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// no bypass here, decode forwards from the wb register instead
	assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
	assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

// File: test/tb_mips_core.sv
module tb_mips_core import mips_pkg::*; ();

	localparam int COLS         = 8; // values per row in the data file
	localparam int MAX_ROWS     = 64;
	localparam int PERIOD       = 100;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY  = 10;

	logic    clk;
	logic    rst_n_i;
	fetch_t  fetch_i;
	wb_t     wb_o;
	branch_t branch_o;

	logic [31:0] vectors [0:MAX_ROWS*COLS];
	int          num_rows;
	logic        loaded;

	mips_core i_dut (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.fetch_i  (fetch_i),
		.wb_o     (wb_o),
		.branch_o (branch_o)
	);

	always #(PERIOD / 2) clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "mismatch, run stopped");
		end
	endtask

	// word 0 holds the row count
	// row fields follow in groups of COLS
	function automatic logic [31:0] row_field(int row, int col);
		return vectors[1 + row * COLS + col];
	endfunction

	task automatic drive_row(int row);
		fetch_i.valid = 1'b1;
		fetch_i.inst  = row_field(row, 0);
		fetch_i.pc    = row_field(row, 1);
	endtask

	task automatic expect_idle(string tag);
		check_val({tag, " wb we"}, 32'd0, 32'(wb_o.we));
		check_val({tag, " branch taken"}, 32'd0, 32'(branch_o.taken));
		check_val({tag, " branch invalid"}, 32'd0, 32'(branch_o.invalid));
	endtask

	task automatic check_branch(int row);
		logic [31:0] exp_taken;
		exp_taken = row_field(row, 5);
		check_val($sformatf("row %0d branch taken", row), exp_taken, 32'(branch_o.taken));
		check_val($sformatf("row %0d branch invalid", row), row_field(row, 7),
			32'(branch_o.invalid));
		if (exp_taken[0]) // target only meaningful when taken
			check_val($sformatf("row %0d branch target", row), row_field(row, 6),
				branch_o.target);
	endtask

	task automatic check_wb(int row);
		logic [31:0] exp_we;
		exp_we = row_field(row, 2);
		check_val($sformatf("row %0d wb we", row), exp_we, 32'(wb_o.we));
		if (exp_we[0]) begin
			check_val($sformatf("row %0d wb addr", row), row_field(row, 3), 32'(wb_o.addr));
			check_val($sformatf("row %0d wb data", row), row_field(row, 4), wb_o.data);
		end
	endtask

	initial begin
		int cycle;
		int rst_cycle;
		clk     = 1'b0;
		rst_n_i = 1'b0;
		fetch_i = '0;
		loaded  = 1'b0;
		$readmemh("test/testdata_core.txt", vectors);
		num_rows = int'(vectors[0]);
		if (num_rows < 1 || num_rows > MAX_ROWS) begin
			$display("the data file holds no usable row count");
			$display("*** FAILED ***");
			$fatal(1, "bad data file");
		end
		loaded = 1'b1;

		// valid words offered during reset must not get through
		for (rst_cycle = 0; rst_cycle < RESET_CYCLES; rst_cycle++) begin
			drive_row(num_rows - 1 - (rst_cycle % num_rows));
			@(posedge clk);
			#DRIVE_DELAY;
			expect_idle("reset");
		end
		rst_n_i = 1'b1;
		fetch_i = '0;

		// branch shows two edges and wb three edges after row c is driven
		for (cycle = 0; cycle < num_rows + 3; cycle++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (cycle < num_rows)
				drive_row(cycle);
			else
				fetch_i = '0;
			if (cycle >= 2 && cycle - 2 < num_rows)
				check_branch(cycle - 2);
			else if (cycle < 2) begin
				check_val("post reset branch taken", 32'd0, 32'(branch_o.taken));
				check_val("post reset branch invalid", 32'd0, 32'(branch_o.invalid));
			end
			if (cycle >= 3)
				check_wb(cycle - 3);
			else
				check_val("post reset wb we", 32'd0, 32'(wb_o.we));
		end

		$display("*** PASSED ***");
		$finish;
	end

	// bound of rows plus reset and drain with margin
	initial begin
		wait (loaded);
		#((num_rows + 10) * PERIOD);
		$display("timeout, the test did not complete in the expected time");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: test/testdata_core.txt
// first value is the row count in hex, then one instruction per row
// inst pc wb_we wb_addr wb_data br_taken br_target br_invalid
22
3C018000 BFC00000 1 01 80000000 0 00000000 0
34211234 BFC00004 1 01 80001234 0 00000000 0
2402FFFF BFC00008 1 02 FFFFFFFF 0 00000000 0
28430001 BFC0000C 1 03 00000001 0 00000000 0
2C440001 BFC00010 1 04 00000000 0 00000000 0
24200005 BFC00014 0 00 00000000 0 00000000 0
00232821 BFC00018 1 05 80001235 0 00000000 0
00A23023 BFC0001C 1 06 80001236 0 00000000 0
00C53826 BFC00020 1 07 00000003 0 00000000 0
0027402A BFC00024 1 08 00000001 0 00000000 0
00E04827 BFC00028 1 09 FFFFFFFC 0 00000000 0
00075100 BFC0002C 1 0A 00000030 0 00000000 0
00015A03 BFC00030 1 0B FF800012 0 00000000 0
00616006 BFC00034 1 0C 4000091A 0 00000000 0
016C680B BFC00038 1 0D FF800012 0 00000000 0
016C700A BFC0003C 0 00 00000000 0 00000000 0
0164700A BFC00040 1 0E FF800012 0 00000000 0
0144780B BFC00044 0 00 00000000 0 00000000 0
10680004 BFC00048 0 00 00000000 1 BFC0005C 0
1468FFFE BFC0004C 0 00 00000000 0 00000000 0
1C200001 BFC00050 0 00 00000000 0 00000000 0
1820FFFC BFC00054 0 00 00000000 1 BFC00048 0
04E10008 BFC00058 0 00 00000000 1 BFC0007C 0
04E00008 BFC0005C 0 00 00000000 0 00000000 0
0440FFFF BFC00060 0 00 00000000 1 BFC00060 0
04110002 BFC00064 1 1F BFC0006C 1 BFC00070 0
04300003 BFC00068 1 1F BFC00070 1 BFC00078 0
0BF00040 BFC0006C 0 00 00000000 1 BFC00100 0
0FF00080 BFC00070 1 1F BFC00078 1 BFC00200 0
03E00008 BFC00074 0 00 00000000 1 BFC00078 0
03E08009 BFC00078 1 10 BFC00080 1 BFC00078 0
FC000000 BFC0007C 0 00 00000000 0 00000000 1
00430801 BFC00080 0 00 00000000 0 00000000 1
02008821 BFC00084 1 11 BFC00080 0 00000000 0
